/* include/dmem_settings.svh */
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// Data word width in bits
`define DMEM_WORD_BITS 32

// Word address width, 1024 words
`define DMEM_ADDR_BITS 10

// Access size codes carried on cpu_size and tga_size
`define DMEM_SIZE_BYTE 2'd0
`define DMEM_SIZE_HALF 2'd1
`define DMEM_SIZE_WORD 2'd2

`endif

/* logic/dmem_pkg.sv */
`include "dmem_settings.svh"

package dmem_pkg;

	// One data word
	typedef logic [`DMEM_WORD_BITS-1:0] word_t;

	// Word-aligned address into the array
	typedef logic [`DMEM_ADDR_BITS-1:0] word_addr_t;

	typedef logic [`DMEM_ADDR_BITS+1:0] byte_addr_t;	// Word address plus 2 offset bits

	// One enable per byte lane
	typedef logic [`DMEM_WORD_BITS/8-1:0] byte_en_t;

	typedef logic [$clog2(`DMEM_WORD_BITS/8)-1:0] byte_off_t;	// Byte inside word

	// Byte, half or word code
	typedef logic [1:0] access_size_t;

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/100ps

interface mem_bus_if;
	import dmem_pkg::*;

	// Wishbone classic request side
	logic cyc;					// Bus cycle active
	logic stb;					// Strobe, request valid
	logic we;					// 1 = store
	word_addr_t adr;			// Word address
	byte_en_t sel;				// Lanes touched
	word_t dat_w;				// Lane-shifted store data

	// Response side
	word_t dat_r;				// Raw word read
	logic ack;					// One-cycle acknowledge

	// Tags for the load path
	access_size_t tga_size;		// Access size
	logic tga_unsigned;			// Zero-extend when set
	byte_off_t tga_off;			// Offset, low bits already cleared

	// Aligner drives the request and tags
	modport master(output cyc, stb, we, adr, sel, dat_w,
		tga_size, tga_unsigned, tga_off);

	// Memory sees only the plain request
	modport slave(input cyc, stb, we, adr, sel, dat_w, output dat_r, ack);

	// Extractor watches the response and tags
	modport monitor(input dat_r, ack, tga_size, tga_unsigned, tga_off);

endinterface

/* logic/store_aligner.sv */
`timescale 1ns/100ps
`include "dmem_settings.svh"

module store_aligner(
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input dmem_pkg::byte_addr_t cpu_addr,
	input dmem_pkg::access_size_t cpu_size,
	input logic cpu_unsigned,
	input dmem_pkg::word_t cpu_wdata,
	mem_bus_if.master bus
);
	import dmem_pkg::*;

	byte_off_t off_clean;		// Offset with sub-size bits forced low
	byte_en_t store_sel;		// Lanes for a store of this size
	word_t lane_data;			// Store data copied into every candidate lane

	// Size decode, misaligned bits simply dropped
	always_comb begin
		case (cpu_size)
			`DMEM_SIZE_BYTE: begin
				off_clean = cpu_addr[1:0];
				lane_data = {4{cpu_wdata[7:0]}};	// Byte in all four lanes
				store_sel = 4'b0001 << off_clean;
			end
			`DMEM_SIZE_HALF: begin
				off_clean = {cpu_addr[1], 1'b0};	// Only bit 1 counts
				lane_data = {2{cpu_wdata[15:0]}};
				store_sel = 4'b0011 << off_clean;
			end
			default: begin
				// Word, unused code 3 handled the same
				off_clean = '0;
				lane_data = cpu_wdata;
				store_sel = '1;
			end
		endcase
	end

	// Handshake straight through
	assign bus.cyc = cpu_cyc;
	assign bus.stb = cpu_stb;
	assign bus.we = cpu_we;

	assign bus.adr = cpu_addr[`DMEM_ADDR_BITS+1:2];	// Drop byte offset
	assign bus.sel = cpu_we ? store_sel : '1;		// Loads read the whole word
	assign bus.dat_w = lane_data;

	// Tags for the extractor
	assign bus.tga_size = cpu_size;
	assign bus.tga_unsigned = cpu_unsigned;
	assign bus.tga_off = off_clean;

endmodule

/* logic/data_memory.sv */
`timescale 1ns/100ps
`include "dmem_settings.svh"

module data_memory(
	input logic CLK,
	input logic reset,

	// Core side, Wishbone classic slave
	mem_bus_if.slave bus,

	// Protocol controller side, no handshake
	input dmem_pkg::byte_en_t con_write,
	input dmem_pkg::word_addr_t con_addr,
	input dmem_pkg::word_t con_in,
	output dmem_pkg::word_t con_out
);
	import dmem_pkg::*;

	word_t mem [0:(1 << `DMEM_ADDR_BITS) - 1];	// Word array, contents not reset

	logic ack_q;				// Core acknowledge flop
	logic access;				// Core request taken at this edge
	logic same_word;			// Both ports on one word
	byte_en_t core_lanes;		// Lanes the core writes this edge
	byte_en_t con_lanes;		// Protocol lanes left after the core claims its own

	// stb is ignored while ack is high, so no double answer
	assign access = bus.cyc & bus.stb & ~ack_q;

	assign core_lanes = (access & bus.we) ? bus.sel : '0;
	assign same_word = (con_addr == bus.adr);

	// Core wins a lane collision
	assign con_lanes = same_word ? (con_write & ~core_lanes) : con_write;

	// Ack one cycle wide, only control state reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign bus.ack = ack_q;

	// Byte-lane writes from both ports
	always_ff @(posedge CLK) begin
		for (int i = 0; i < `DMEM_WORD_BITS/8; i++) begin
			if (con_lanes[i]) begin
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			end
			if (core_lanes[i]) begin
				mem[bus.adr][8*i +: 8] <= bus.dat_w[8*i +: 8];
			end
		end
	end

	// Read-first on both ports
	always_ff @(posedge CLK) begin
		if (access) begin
			bus.dat_r <= mem[bus.adr];	// Old word even on a store
		end
		con_out <= mem[con_addr];		// Every edge, one cycle late
	end

endmodule

/* logic/load_extractor.sv */
`timescale 1ns/100ps
`include "dmem_settings.svh"

module load_extractor(
	mem_bus_if.monitor bus,
	output dmem_pkg::word_t cpu_rdata,
	output logic cpu_ack
);

	logic [7:0] sel_byte;		// Addressed byte
	logic [15:0] sel_half;		// Addressed half
	logic byte_fill;			// Extension bit for a byte
	logic half_fill;			// Extension bit for a half

	// tga_off arrives cleaned, used as is
	assign sel_byte = bus.dat_r[8*bus.tga_off +: 8];
	assign sel_half = bus.dat_r[16*bus.tga_off[1] +: 16];

	// Sign bit unless unsigned load
	assign byte_fill = ~bus.tga_unsigned & sel_byte[7];
	assign half_fill = ~bus.tga_unsigned & sel_half[15];

	always_comb begin
		case (bus.tga_size)
			`DMEM_SIZE_BYTE: begin
				cpu_rdata = {{(`DMEM_WORD_BITS-8){byte_fill}}, sel_byte};
			end
			`DMEM_SIZE_HALF: begin
				cpu_rdata = {{(`DMEM_WORD_BITS-16){half_fill}}, sel_half};
			end
			default: begin
				cpu_rdata = bus.dat_r;	// Word unchanged
			end
		endcase
	end

	// Data valid while ack is high, meaningless on a store
	assign cpu_ack = bus.ack;

endmodule

/* logic/dmem_subsystem.sv */
`timescale 1ns/100ps

module dmem_subsystem(
	input logic CLK,
	input logic reset,

	// Core port, Wishbone classic master side
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input dmem_pkg::byte_addr_t cpu_addr,
	input dmem_pkg::access_size_t cpu_size,
	input logic cpu_unsigned,
	input dmem_pkg::word_t cpu_wdata,

	// Core port, slave side
	output logic cpu_ack,
	output dmem_pkg::word_t cpu_rdata,

	// Protocol controllers
	input dmem_pkg::byte_en_t con_write,
	input dmem_pkg::word_addr_t con_addr,	// Word address
	input dmem_pkg::word_t con_in,
	output dmem_pkg::word_t con_out			// Registered old contents
);

	mem_bus_if bus();			// Aligner to memory to extractor

	// Request shaping, no latency
	store_aligner aligner(
		.cpu_cyc(cpu_cyc),
		.cpu_stb(cpu_stb),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_size(cpu_size),
		.cpu_unsigned(cpu_unsigned),
		.cpu_wdata(cpu_wdata),
		.bus(bus.master)
	);

	// Dual-port array, one cycle each port
	data_memory memory(
		.CLK(CLK),
		.reset(reset),
		.bus(bus.slave),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	// Lane select and extension
	load_extractor extractor(
		.bus(bus.monitor),
		.cpu_rdata(cpu_rdata),
		.cpu_ack(cpu_ack)
	);

endmodule

/* bench/dmem_tb.sv */
`timescale 1ns/100ps
`include "dmem_settings.svh"

module dmem_tb;
	import dmem_pkg::*;

	logic CLK;
	logic reset;
	logic cpu_cyc;
	logic cpu_stb;
	logic cpu_we;
	byte_addr_t cpu_addr;
	access_size_t cpu_size;
	logic cpu_unsigned;
	word_t cpu_wdata;
	logic cpu_ack;
	word_t cpu_rdata;
	byte_en_t con_write;
	word_addr_t con_addr;
	word_t con_in;
	word_t con_out;

	int errors = 0;
	int checks = 0;

	logic [7:0] model_mem [0:(4 << `DMEM_ADDR_BITS) - 1];	// Byte-level mirror of the array

	dmem_subsystem dut(.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;		// 8 ns period
	end

	function automatic word_addr_t word_of(input byte_addr_t a);
		return a[`DMEM_ADDR_BITS+1:2];
	endfunction

	// Whole word from the mirror, lane 0 lowest
	function automatic word_t model_word(input word_addr_t wa);
		return {model_mem[{wa, 2'd3}], model_mem[{wa, 2'd2}],
			model_mem[{wa, 2'd1}], model_mem[{wa, 2'd0}]};
	endfunction

	// Expected load result, sub-size offset bits ignored
	function automatic word_t model_load(input byte_addr_t a, input access_size_t size,
		input logic uns);
		logic [7:0] b;
		logic [15:0] h;
		byte_addr_t base;
		case (size)
			`DMEM_SIZE_BYTE: begin
				b = model_mem[a];
				return uns ? {{(`DMEM_WORD_BITS-8){1'b0}}, b} : {{(`DMEM_WORD_BITS-8){b[7]}}, b};
			end
			`DMEM_SIZE_HALF: begin
				base = {a[`DMEM_ADDR_BITS+1:1], 1'b0};	// Bit 0 dropped
				h = {model_mem[base | 12'd1], model_mem[base]};
				return uns ? {{(`DMEM_WORD_BITS-16){1'b0}}, h} : {{(`DMEM_WORD_BITS-16){h[15]}}, h};
			end
			default: return model_word(word_of(a));
		endcase
	endfunction

	task automatic model_store(input byte_addr_t a, input access_size_t size, input word_t d);
		byte_addr_t base;
		case (size)
			`DMEM_SIZE_BYTE: model_mem[a] = d[7:0];
			`DMEM_SIZE_HALF: begin
				base = {a[`DMEM_ADDR_BITS+1:1], 1'b0};
				model_mem[base] = d[7:0];
				model_mem[base | 12'd1] = d[15:8];
			end
			default: begin
				for (int i = 0; i < 4; i++) begin
					model_mem[{word_of(a), 2'(i)}] = d[8*i +: 8];
				end
			end
		endcase
	endtask

	// Protocol-port lanes into the mirror
	task automatic model_con_write(input word_addr_t wa, input byte_en_t en, input word_t d);
		for (int i = 0; i < 4; i++) begin
			if (en[i]) model_mem[{wa, 2'(i)}] = d[8*i +: 8];
		end
	endtask

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// One Wishbone access, optional protocol write in the sampling cycle
	task automatic run_access(input logic we, input byte_addr_t a, input access_size_t size,
		input logic uns, input word_t d, input byte_en_t con_en, input word_t con_d,
		input string name, output word_t rdata, output word_t con_seen);
		int waited;
		logic got;
		@(posedge CLK);
		#1;
		cpu_cyc = 1'b1;
		cpu_stb = 1'b1;
		cpu_we = we;
		cpu_addr = a;
		cpu_size = size;
		cpu_unsigned = uns;
		cpu_wdata = d;
		con_write = con_en;
		con_addr = word_of(a);
		con_in = con_d;
		@(negedge CLK);			// Request not sampled yet
		checks++;
		assert (cpu_ack === 1'b0) else begin
			$display("%s: ack rose before the request was sampled", name);
			errors++;
		end
		@(posedge CLK);			// Edge that samples stb
		#1 con_write = '0;
		waited = 0;
		got = 1'b0;
		while (!got && waited < 10) begin
			@(negedge CLK);
			waited++;
			if (cpu_ack === 1'b1) got = 1'b1;
		end
		checks++;
		assert (got) else begin
			$display("%s: ack never came within 10 cycles", name);
			errors++;
		end
		if (got) begin
			checks++;
			assert (waited == 1) else begin
				$display("Fail %s ack delay: expected 1, actual %0d", name, waited);
				errors++;
			end
		end
		rdata = cpu_rdata;
		con_seen = con_out;		// Read-first result of the sampling edge
		@(posedge CLK);			// stb still high here, must be ignored
		#1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		@(negedge CLK);
		checks++;
		assert (cpu_ack === 1'b0) else begin
			$display("%s: ack answered twice or stayed high", name);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int chk0, input int err0);
		$display("[%s] %0d checks, %0d wrong", name, checks - chk0, errors - err0);
	endtask

	initial begin
		word_t rd;
		word_t cs;
		word_t old;
		word_t wdata;
		word_t cdata;
		byte_addr_t addr;
		access_size_t size;
		logic uns;
		logic we;
		int chk0;
		int err0;

		void'($urandom(29));
		reset = 1'b1;
		cpu_cyc = 1'b1;			// Load request pending through reset
		cpu_stb = 1'b1;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_size = '0;
		cpu_unsigned = 1'b0;
		cpu_wdata = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;

		// Reset held 8 edges with stb high, ack low throughout and right after
		chk0 = checks;
		err0 = errors;
		repeat (8) begin
			@(posedge CLK);
			#1;
			checks++;
			assert (cpu_ack === 1'b0) else begin
				$display("cpu_ack went high during reset");
				errors++;
			end
		end
		reset = 1'b0;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		repeat (2) begin
			@(negedge CLK);
			checks++;
			assert (cpu_ack === 1'b0) else begin
				$display("cpu_ack went high just after reset");
				errors++;
			end
		end
		report_test("reset", chk0, err0);

		// Fill every word through the protocol port
		chk0 = checks;
		err0 = errors;
		for (int w = 0; w < (1 << `DMEM_ADDR_BITS); w++) begin
			@(posedge CLK);
			#1;
			con_write = '1;
			con_addr = word_addr_t'(w);
			con_in = $urandom;
			model_con_write(con_addr, con_write, con_in);
		end
		@(posedge CLK);
		#1 con_write = '0;
		for (int w = 0; w < (1 << `DMEM_ADDR_BITS); w++) begin
			@(posedge CLK);
			#1 con_addr = word_addr_t'(w);
			@(posedge CLK);		// con_out registered here
			@(negedge CLK);
			compare_word("fill", model_word(word_addr_t'(w)), con_out);
		end
		report_test("fill", chk0, err0);

		// Store, then read the whole word back
		chk0 = checks;
		err0 = errors;
		repeat (200) begin
			size = access_size_t'($urandom % 3);
			addr = byte_addr_t'($urandom);
			wdata = $urandom;
			run_access(1'b1, addr, size, 1'b0, wdata, '0, '0, "stores", rd, cs);
			model_store(addr, size, wdata);
			run_access(1'b0, {word_of(addr), 2'($urandom)}, `DMEM_SIZE_WORD, 1'b0, '0, '0, '0,
				"stores", rd, cs);
			compare_word("stores", model_word(word_of(addr)), rd);
		end
		report_test("stores", chk0, err0);

		// Byte and half loads, both extensions
		chk0 = checks;
		err0 = errors;
		repeat (200) begin
			size = access_size_t'($urandom % 2);
			uns = 1'($urandom);
			addr = byte_addr_t'($urandom);
			run_access(1'b0, addr, size, uns, '0, '0, '0, "loads", rd, cs);
			compare_word("loads", model_load(addr, size, uns), rd);
		end
		report_test("loads", chk0, err0);

		// Mixed traffic, timing checked inside every access
		chk0 = checks;
		err0 = errors;
		repeat (40) begin
			we = 1'($urandom);
			size = access_size_t'($urandom % 3);
			uns = 1'($urandom);
			addr = byte_addr_t'($urandom);
			wdata = $urandom;
			run_access(we, addr, size, uns, wdata, '0, '0, "timing", rd, cs);
			if (we) model_store(addr, size, wdata);
			else compare_word("timing", model_load(addr, size, uns), rd);
		end
		report_test("timing", chk0, err0);

		// Same word written from both ports at one edge
		chk0 = checks;
		err0 = errors;
		repeat (50) begin
			size = access_size_t'($urandom % 3);
			addr = byte_addr_t'($urandom);
			wdata = $urandom;
			cdata = $urandom;
			old = model_word(word_of(addr));
			run_access(1'b1, addr, size, 1'b0, wdata, '1, cdata, "collisions", rd, cs);
			compare_word("collisions old word", old, cs);
			model_con_write(word_of(addr), '1, cdata);
			model_store(addr, size, wdata);		// Core lanes last, so they win
			run_access(1'b0, addr, `DMEM_SIZE_WORD, 1'b0, '0, '0, '0, "collisions", rd, cs);
			compare_word("collisions", model_word(word_of(addr)), rd);
		end
		report_test("collisions", chk0, err0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
logic/dmem_pkg.sv
logic/mem_bus_if.sv
logic/store_aligner.sv
logic/data_memory.sv
logic/load_extractor.sv
logic/dmem_subsystem.sv
bench/dmem_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP = dmem_tb
FILELIST = sources.f
OBJDIR = obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
